//--- riscv_core.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/core_pkg.sv
hw/decode_if.sv
hw/insn_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/pc_unit.sv
hw/riscv_core.sv
testbench/tb_riscv_core.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_riscv_core
FILELIST = riscv_core.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(BUILD)

//--- testbench/tb_riscv_core.sv
`timescale 1ns/1ps

module tb_riscv_core;

  localparam int CLK_PERIOD = 40;
  localparam int MEM_WORDS  = 64;
  localparam int N_TESTS    = 4;
  // reset, longest program, halt hold and some slack
  localparam int TEST_CYCLES = MEM_WORDS + 16;
  localparam int TIMEOUT_NS  = N_TESTS * TEST_CYCLES * CLK_PERIOD + 2000;
  localparam logic [6:0]  OPC_IMM = 7'b0010011;
  localparam logic [31:0] ECALL   = 32'h0000_0073;

  logic        clk;
  logic        rst;
  logic [31:0] insn;
  logic [31:0] pc;
  logic [31:0] store_addr;
  logic [31:0] store_data;
  logic        store_en;
  logic        halt;

  logic [31:0] imem [MEM_WORDS];
  logic [31:0] prog [$];
  logic [31:0] exp_pc [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] got_pc [$];
  logic [31:0] got_addr [$];
  logic [31:0] got_data [$];

  riscv_core uut (
    .clk        (clk),
    .rst        (rst),
    .insn       (insn),
    .pc         (pc),
    .store_addr (store_addr),
    .store_data (store_data),
    .store_en   (store_en),
    .halt       (halt)
  );

  // instruction memory, word indexed
  assign insn = imem[pc[7:2]];

  always #(CLK_PERIOD / 2) clk = ~clk;

  // pc trace of executed instructions and every store
  always @(posedge clk) begin
    if (!rst && !halt) begin
      got_pc.push_back(pc);
    end
    if (store_en) begin
      got_addr.push_back(store_addr);
      got_data.push_back(store_data);
    end
  end

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  // addi x0, x0, index: harmless and unique per word
  function automatic logic [31:0] fill_word(input int idx);
    return enc_i(12'(idx), 5'd0, 3'b000, 5'd0, OPC_IMM);
  endfunction

  task automatic check(input string what, input logic [31:0] want, input logic [31:0] got);
    if (want !== got) begin
      $display("Fail %s: expected %h, actual %h", what, want, got);
      $display(">>> FAIL");
      $fatal(1, "mismatch in %s", what);
    end
  endtask

  task automatic start_program();
    prog.delete();
    exp_pc.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  // traced words are expected in the executed pc sequence
  task automatic emit(input logic [31:0] word, input bit traced);
    if (traced) begin
      exp_pc.push_back(32'(prog.size() * 4));
    end
    prog.push_back(word);
  endtask

  task automatic emit_sw(input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] off,
                         input logic [31:0] base, input logic [31:0] data, input bit runs);
    emit(enc_s(off, rs2, rs1), runs);
    if (runs) begin
      exp_addr.push_back(base + {{20{off[11]}}, off});
      exp_data.push_back(data);
    end
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    // addi sign-extends its immediate, so round the upper part
    upper = value + 32'h800;
    emit(enc_u(upper[31:12], rd), 1'b1);
    emit(enc_i(value[11:0], rd, 3'b000, rd, OPC_IMM), 1'b1);
  endtask

  task automatic op_imm(input logic [2:0] f3, input logic [11:0] imm, input logic [31:0] want);
    emit(enc_i(imm, 5'd1, f3, 5'd2, OPC_IMM), 1'b1);
    emit_sw(5'd2, 5'd0, 12'(prog.size() * 4), 32'h0, want, 1'b1);
  endtask

  task automatic op_reg(input logic [6:0] f7, input logic [2:0] f3, input logic [31:0] want);
    emit(enc_r(f7, 5'd2, 5'd1, f3, 5'd3), 1'b1);
    emit_sw(5'd3, 5'd0, 12'(prog.size() * 4), 32'h0, want, 1'b1);
  endtask

  // branch over one store of x3
  task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                        input bit taken, input logic [31:0] data);
    emit(enc_b(13'd8, rs2, rs1, f3), 1'b1);
    emit_sw(5'd3, 5'd0, 12'(prog.size() * 4), 32'h0, data, !taken);
  endtask

  task automatic run_program(input string name);
    logic [31:0] held;
    @(posedge clk);
    #1;
    rst = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : fill_word(i);
    end
    got_pc.delete();
    got_addr.delete();
    got_data.delete();
    repeat (2) @(posedge clk);
    #1;
    check({name, " pc in reset"}, 32'h0, pc);
    // an ecall and then a store at pc 0 while reset is still high
    imem[0] = ECALL;
    #1;
    check({name, " halt in reset"}, 32'h0, 32'(halt));
    imem[0] = enc_s(12'h000, 5'd0, 5'd0);
    #1;
    check({name, " store_en in reset"}, 32'h0, 32'(store_en));
    imem[0] = prog[0];
    #1;
    rst = 1'b0;
    #1;
    check({name, " halt after reset"}, 32'h0, 32'(halt));
    while (halt !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    held = pc;
    check({name, " halt pc"}, 32'((prog.size() - 1) * 4), held);
    repeat (4) @(posedge clk);
    #1;
    check({name, " pc while halted"}, held, pc);
    check({name, " halt held"}, 32'h1, 32'(halt));
    check({name, " store count"}, 32'(exp_addr.size()), 32'(got_addr.size()));
    for (int i = 0; i < exp_addr.size(); i++) begin
      check($sformatf("%s store %0d addr", name, i), exp_addr[i], got_addr[i]);
      check($sformatf("%s store %0d data", name, i), exp_data[i], got_data[i]);
    end
    check({name, " pc trace length"}, 32'(exp_pc.size()), 32'(got_pc.size()));
    for (int i = 0; i < exp_pc.size(); i++) begin
      check($sformatf("%s pc step %0d", name, i), exp_pc[i], got_pc[i]);
    end
  endtask

  task automatic test_reg_imm();
    logic [31:0] a;
    logic [11:0] imm;
    logic [11:0] neg;
    logic [4:0]  sh;
    // negative rs1 against a positive immediate: slti 1, sltiu 0
    a   = $urandom() | 32'h8000_0000;
    imm = 12'($urandom()) & 12'h7ff;
    neg = imm | 12'h800;
    sh  = 5'($urandom());
    start_program();
    load_const(5'd1, a);
    op_imm(3'b000, imm, a + {20'h0, imm});
    op_imm(3'b000, neg, a + {20'hfffff, neg});
    op_imm(3'b010, imm, 32'd1);
    op_imm(3'b011, imm, 32'd0);
    op_imm(3'b100, imm, a ^ {20'h0, imm});
    op_imm(3'b110, imm, a | {20'h0, imm});
    op_imm(3'b111, neg, a & {20'hfffff, neg});
    op_imm(3'b001, {7'b0, sh}, a << sh);
    op_imm(3'b101, {7'b0, sh}, a >> sh);
    op_imm(3'b101, {7'b0100000, sh}, ~(~a >> sh));
    emit(ECALL, 1'b0);
    run_program("reg_imm");
  endtask

  task automatic test_reg_reg();
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    a  = $urandom() | 32'h8000_0000;
    b  = $urandom() & 32'h7fff_ffff;
    sh = b[4:0];
    start_program();
    load_const(5'd1, a);
    load_const(5'd2, b);
    op_reg(7'h00, 3'b000, a + b);
    op_reg(7'h20, 3'b000, a - b);
    op_reg(7'h00, 3'b001, a << sh);
    op_reg(7'h00, 3'b010, 32'd1);
    op_reg(7'h00, 3'b011, 32'd0);
    op_reg(7'h00, 3'b100, a ^ b);
    op_reg(7'h00, 3'b101, a >> sh);
    op_reg(7'h20, 3'b101, ~(~a >> sh));
    op_reg(7'h00, 3'b110, a | b);
    op_reg(7'h00, 3'b111, a & b);
    // add into x0, then store x0
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0), 1'b1);
    emit_sw(5'd0, 5'd0, 12'(prog.size() * 4), 32'h0, 32'h0, 1'b1);
    emit(ECALL, 1'b0);
    run_program("reg_reg");
  endtask

  task automatic test_lui_sw();
    logic [19:0] upper;
    logic [31:0] base;
    logic [11:0] off;
    upper = 20'($urandom());
    base  = $urandom();
    off   = 12'($urandom());
    start_program();
    emit(enc_u(upper, 5'd4), 1'b1);
    emit_sw(5'd4, 5'd0, 12'h010, 32'h0, {upper, 12'h000}, 1'b1);
    load_const(5'd5, base);
    emit_sw(5'd4, 5'd5, 12'hff8, base, {upper, 12'h000}, 1'b1);
    emit_sw(5'd4, 5'd5, off, base, {upper, 12'h000}, 1'b1);
    emit(ECALL, 1'b0);
    run_program("lui_sw");
  endtask

  task automatic test_branches();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    a = $urandom() | 32'h8000_0000;
    b = $urandom() & 32'h7fff_ffff;
    c = $urandom();
    start_program();
    load_const(5'd1, a);
    load_const(5'd2, b);
    load_const(5'd3, c);
    // x1 < x2 as signed, x1 > x2 as unsigned
    branch(3'b000, 5'd1, 5'd1, 1'b1, c);
    branch(3'b000, 5'd1, 5'd2, 1'b0, c);
    branch(3'b001, 5'd1, 5'd2, 1'b1, c);
    branch(3'b001, 5'd1, 5'd1, 1'b0, c);
    branch(3'b100, 5'd1, 5'd2, 1'b1, c);
    branch(3'b100, 5'd2, 5'd1, 1'b0, c);
    branch(3'b101, 5'd2, 5'd1, 1'b1, c);
    branch(3'b101, 5'd1, 5'd2, 1'b0, c);
    branch(3'b110, 5'd2, 5'd1, 1'b1, c);
    branch(3'b110, 5'd1, 5'd2, 1'b0, c);
    branch(3'b111, 5'd1, 5'd2, 1'b1, c);
    branch(3'b111, 5'd2, 5'd1, 1'b0, c);
    emit(ECALL, 1'b0);
    run_program("branches");
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = fill_word(i);
    end
    void'($urandom(32'h6ccc_49e7));
    test_reg_imm();
    test_reg_reg();
    test_lui_sw();
    test_branches();
    $display(">>> PASS");
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the core never halted within %0d ns", TIMEOUT_NS);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- hw/riscv_core.sv
`timescale 1ns/1ps

module riscv_core
  import rv_isa_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  word_t insn,
  output word_t pc,
  output word_t store_addr,
  output word_t store_data,
  output logic  store_en,
  output logic  halt
);

  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;

  decode_if dec ();

  insn_decoder u_decoder (
    .insn (insn),
    .dec  (dec)
  );

  // halt blocks the write of the ecall cycle and beyond
  reg_file u_reg_file (
    .clk         (clk),
    .rst         (rst),
    .dec         (dec),
    .rd_data     (alu_result),
    .write_block (halt),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data)
  );

  alu u_alu (
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (alu_result)
  );

  pc_unit u_pc_unit (
    .clk      (clk),
    .rst      (rst),
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc),
    .halt     (halt)
  );

  // store address comes from the alu adder
  assign store_addr = alu_result;
  assign store_data = rs2_data;
  assign store_en   = dec.is_store && !rst && !halt;

endmodule

//--- hw/pc_unit.sv
`timescale 1ns/1ps

`include "riscv_macros.svh"

module pc_unit
  import rv_isa_pkg::*;
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  decode_if.pc_side dec,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output word_t     pc,
  output logic      halt
);

  logic  taken;
  word_t next_pc;

  always_comb begin
    case (dec.branch_cond)
      BR_EQ:   taken = (rs1_data == rs2_data);
      BR_NE:   taken = (rs1_data != rs2_data);
      BR_LT:   taken = ($signed(rs1_data) < $signed(rs2_data));
      BR_GE:   taken = ($signed(rs1_data) >= $signed(rs2_data));
      BR_LTU:  taken = (rs1_data < rs2_data);
      BR_GEU:  taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  // b immediate already carries the zero lsb
  assign next_pc = taken ? pc + dec.imm : pc + word_t'(`PC_STEP);

  assign halt = dec.is_halt && !rst;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (!halt) begin
      pc <= next_pc;
    end
  end

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps

`include "riscv_macros.svh"

module alu
  import rv_isa_pkg::*;
  import core_pkg::*;
(
  decode_if.alu_side dec,
  input  word_t      rs1_data,
  input  word_t      rs2_data,
  output word_t      result
);

  word_t      op_b;
  logic [4:0] shamt;

  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    result = rs1_data + op_b;
      ALU_SUB:    result = rs1_data - op_b;
      ALU_SLL:    result = rs1_data << shamt;
      ALU_SLT:    result = {{(`XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
      ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, rs1_data < op_b};
      ALU_XOR:    result = rs1_data ^ op_b;
      ALU_SRL:    result = rs1_data >> shamt;
      // sign fills from the left
      ALU_SRA:    result = word_t'($signed(rs1_data) >>> shamt);
      ALU_OR:     result = rs1_data | op_b;
      ALU_AND:    result = rs1_data & op_b;
      // lui, upper immediate straight through
      ALU_PASS_B: result = op_b;
      default:    result = '0;
    endcase
  end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps

`include "riscv_macros.svh"

module reg_file
  import rv_isa_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  decode_if.rf_side     dec,
  input  word_t         rd_data,
  input  logic          write_block,
  output word_t         rs1_data,
  output word_t         rs2_data
);

  word_t regs [`NUM_REGS];

  // two asynchronous read ports
  assign rs1_data = regs[dec.rs1];
  assign rs2_data = regs[dec.rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (dec.reg_write && !write_block && dec.rd != '0) begin
      // x0 keeps its reset value
      regs[dec.rd] <= rd_data;
    end
  end

  // x0 reads zero once reset has been applied
  x0_reads_zero: assert property (
    @(posedge clk) disable iff (rst) (dec.rs1 == '0) |-> (rs1_data == '0)
  );

endmodule

//--- hw/insn_decoder.sv
`timescale 1ns/1ps

`include "riscv_macros.svh"

module insn_decoder
  import rv_isa_pkg::*;
  import core_pkg::*;
(
  input  word_t      insn,
  decode_if.producer dec
);

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  opcode_t    opcode;
  funct3_t    funct3;
  logic [6:0] funct7;
  logic       f7_base;
  logic       f7_alt;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;

  assign opcode  = insn[6:0];
  assign funct3  = insn[14:12];
  assign funct7  = insn[31:25];
  assign f7_base = (funct7 == F7_BASE);
  assign f7_alt  = (funct7 == F7_ALT);

  // register fields sit at fixed positions in every format
  assign dec.rd  = insn[11:7];
  assign dec.rs1 = insn[19:15];
  assign dec.rs2 = insn[24:20];

  // sign always comes from insn[31]
  assign imm_i = {{(`XLEN-12){insn[31]}}, insn[31:20]};
  assign imm_s = {{(`XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{(`XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    dec.imm         = imm_i;
    dec.alu_op      = ALU_ADD;
    dec.use_imm     = 1'b0;
    dec.reg_write   = 1'b0;
    dec.is_store    = 1'b0;
    dec.branch_cond = BR_NONE;
    dec.is_halt     = 1'b0;
    case (opcode)
      OP_REG_IMM: begin
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        case (funct3)
          3'b000: dec.alu_op = ALU_ADD;
          3'b010: dec.alu_op = ALU_SLT;
          3'b011: dec.alu_op = ALU_SLTU;
          3'b100: dec.alu_op = ALU_XOR;
          3'b110: dec.alu_op = ALU_OR;
          3'b111: dec.alu_op = ALU_AND;
          3'b001: begin
            dec.alu_op    = ALU_SLL;
            dec.reg_write = f7_base;
          end
          default: begin
            // srli / srai share funct3, funct7 picks the kind
            if (f7_alt) begin
              dec.alu_op = ALU_SRA;
            end else begin
              dec.alu_op = ALU_SRL;
            end
            dec.reg_write = f7_base || f7_alt;
          end
        endcase
      end
      OP_REG_REG: begin
        dec.reg_write = f7_base;
        case (funct3)
          3'b000: begin
            if (f7_alt) begin
              dec.alu_op = ALU_SUB;
            end else begin
              dec.alu_op = ALU_ADD;
            end
            dec.reg_write = f7_base || f7_alt;
          end
          3'b001: dec.alu_op = ALU_SLL;
          3'b010: dec.alu_op = ALU_SLT;
          3'b011: dec.alu_op = ALU_SLTU;
          3'b100: dec.alu_op = ALU_XOR;
          3'b101: begin
            if (f7_alt) begin
              dec.alu_op = ALU_SRA;
            end else begin
              dec.alu_op = ALU_SRL;
            end
            dec.reg_write = f7_base || f7_alt;
          end
          3'b110: dec.alu_op = ALU_OR;
          default: dec.alu_op = ALU_AND;
        endcase
      end
      OP_LUI: begin
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.alu_op    = ALU_PASS_B;
        dec.reg_write = 1'b1;
      end
      OP_BRANCH: begin
        dec.imm = imm_b;
        case (funct3)
          3'b000: dec.branch_cond = BR_EQ;
          3'b001: dec.branch_cond = BR_NE;
          3'b100: dec.branch_cond = BR_LT;
          3'b101: dec.branch_cond = BR_GE;
          3'b110: dec.branch_cond = BR_LTU;
          3'b111: dec.branch_cond = BR_GEU;
          default: dec.branch_cond = BR_NONE;
        endcase
      end
      OP_STORE: begin
        // word stores only
        dec.imm      = imm_s;
        dec.use_imm  = 1'b1;
        dec.is_store = (funct3 == 3'b010);
      end
      OP_SYSTEM: begin
        // ecall, every field above the opcode zero
        dec.is_halt = (insn[31:7] == '0);
      end
      default: begin
      end
    endcase
  end

endmodule

//--- hw/decode_if.sv
`timescale 1ns/1ps

interface decode_if
  import rv_isa_pkg::*, core_pkg::*;
();

  reg_addr_t    rd;
  reg_addr_t    rs1;
  reg_addr_t    rs2;
  word_t        imm;
  alu_op_e      alu_op;
  logic         use_imm;
  logic         reg_write;
  logic         is_store;
  branch_cond_e branch_cond;
  logic         is_halt;

  modport producer (
    output rd, rs1, rs2, imm, alu_op, use_imm, reg_write, is_store, branch_cond, is_halt
  );

  modport alu_side (input alu_op, use_imm, imm, is_store);

  modport pc_side (input branch_cond, imm, is_halt);

  modport rf_side (input rd, rs1, rs2, reg_write);

endinterface

//--- hw/core_pkg.sv
package core_pkg;

  // operation selected for the ALU
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // condition tested by the pc unit, BR_NONE for non-branches
  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_EQ   = 3'd1,
    BR_NE   = 3'd2,
    BR_LT   = 3'd3,
    BR_GE   = 3'd4,
    BR_LTU  = 3'd5,
    BR_GEU  = 3'd6
  } branch_cond_e;

endpackage

//--- hw/rv_isa_pkg.sv
`include "riscv_macros.svh"

package rv_isa_pkg;

  // data, address and pc values
  typedef logic [`XLEN-1:0] word_t;

  // register index into the integer file
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // major opcode, insn[6:0]
  typedef logic [6:0] opcode_t;

  // minor opcode, insn[14:12]
  typedef logic [2:0] funct3_t;

  // only the opcodes this core executes
  localparam opcode_t OP_REG_IMM = 7'b0010011;
  localparam opcode_t OP_REG_REG = 7'b0110011;
  localparam opcode_t OP_LUI     = 7'b0110111;
  localparam opcode_t OP_BRANCH  = 7'b1100011;
  localparam opcode_t OP_STORE   = 7'b0100011;
  localparam opcode_t OP_SYSTEM  = 7'b1110011;

endpackage

//--- hw/riscv_macros.svh
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// data and address word width
`define XLEN 32

// architectural integer registers
`define NUM_REGS 32

// register index width
`define REG_ADDR_W 5

// byte increment of a sequential pc
`define PC_STEP 4

`endif
